// ==== source/mdu_data_pkg.sv ====
// multiply/divide unit data types, word widths and the shared result word
package mdu_data_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;

    typedef logic [2*XLEN-1:0] dword_t;

    // divide result as it appears on the response, remainder in the upper word
    typedef struct packed {
        word_t remainder;
        word_t quotient;
    } div_pair_t;

    // one finished result, written as a product or as a quotient/remainder pair
    typedef union packed {
        dword_t    product;
        div_pair_t division;
    } mdu_result_u;

    typedef struct packed {
        word_t hi;
        word_t lo;
    } mdu_rsp_t;

endpackage

// ==== source/mdu_op_pkg.sv ====
// multiply/divide unit operation codes, request layout and decoded control
package mdu_op_pkg;

    import mdu_data_pkg::*;

    typedef enum logic [1:0] {
        op_mul  = 2'd0,  // signed multiply
        op_mulu = 2'd1,
        op_div  = 2'd2,  // signed divide
        op_divu = 2'd3
    } mdu_op_e;

    typedef struct packed {
        mdu_op_e op;
        word_t   a;
        word_t   b;
    } mdu_req_t;

    typedef struct packed {
        logic is_div;
        logic is_signed;
    } mdu_ctrl_t;

endpackage

// ==== source/mdu_decode.sv ====
// request decode, tracks the operation in flight and starts one execute unit
`timescale 1ns/10ps

module mdu_decode
    import mdu_data_pkg::*;
    import mdu_op_pkg::*;
(
    input  logic      CLK,
    input  logic      RST,
    input  mdu_req_t  req,
    input  logic      req_valid,
    output logic      req_ready,
    input  logic      rsp_taken,
    output word_t     a,
    output word_t     b,
    output mdu_ctrl_t ctrl,
    output logic      mul_start,
    output logic      div_start
);

    logic      busy;
    logic      busy_next;
    logic      accept;
    mdu_ctrl_t ctrl_dec;

    assign accept    = req_valid & req_ready;
    assign busy_next = accept | (busy & ~rsp_taken);  // free again once the response leaves

    always_comb begin
        ctrl_dec = '0;
        case (req.op)
            op_mul:  ctrl_dec.is_signed = 1'b1;
            op_mulu: ctrl_dec.is_signed = 1'b0;
            op_div: begin
                ctrl_dec.is_div    = 1'b1;
                ctrl_dec.is_signed = 1'b1;
            end
            default: ctrl_dec.is_div = 1'b1;
        endcase
    end

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            busy      <= 1'b0;
            req_ready <= 1'b0;
            mul_start <= 1'b0;
            div_start <= 1'b0;
        end else begin
            busy      <= busy_next;
            req_ready <= ~busy_next;
            mul_start <= accept & ~ctrl_dec.is_div;
            div_start <= accept & ctrl_dec.is_div;
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            a    <= req.a;
            b    <= req.b;
            ctrl <= ctrl_dec;
        end
    end

endmodule

// ==== source/mdu_multiplier.sv ====
// 32x32 signed/unsigned multiplier, partial products summed in a balanced adder tree
`timescale 1ns/10ps

module mdu_multiplier
    import mdu_data_pkg::*;
(
    input  logic   CLK,
    input  logic   RST,
    input  word_t  a,
    input  word_t  b,
    input  logic   is_signed,
    input  logic   mul_start,
    output dword_t product,
    output logic   product_valid
);

    localparam int NPP = 2 * XLEN;  // one partial product per bit of the extended b

    dword_t a_ext;
    dword_t b_ext;
    dword_t tree [2*NPP-1];  // heap order, node n sums nodes 2n+1 and 2n+2

    // the product modulo 2**64 of the extended operands is the full product
    assign a_ext = is_signed ? {{XLEN{a[XLEN-1]}}, a} : {{XLEN{1'b0}}, a};
    assign b_ext = is_signed ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};

    genvar i;
    generate
        for (i = 0; i < NPP; i++) begin : g_pp
            assign tree[NPP-1+i] = b_ext[i] ? (a_ext << i) : '0;
        end
        for (i = 0; i < NPP - 1; i++) begin : g_add
            assign tree[i] = tree[2*i+1] + tree[2*i+2];
        end
    endgenerate

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            product_valid <= 1'b0;
        end else begin
            product_valid <= mul_start;
        end
    end

    always_ff @(posedge CLK) begin
        if (mul_start) begin
            product <= tree[0];
        end
    end

endmodule

// ==== source/mdu_divider.sv ====
// iterative non-restoring divider on magnitudes with sign and corner-case fixup
`timescale 1ns/10ps

module mdu_divider
    import mdu_data_pkg::*;
(
    input  logic  CLK,
    input  logic  RST,
    input  word_t a,
    input  word_t b,
    input  logic  is_signed,
    input  logic  div_start,
    output word_t quotient,
    output word_t remainder,
    output logic  div_done
);

    localparam int CW = $clog2(XLEN) + 1;

    logic            busy;
    logic [CW-1:0]   count;
    logic            last;
    logic [XLEN:0]   part_rem;  // partial remainder with its sign bit on top
    logic [XLEN+1:0] shifted;
    logic [XLEN+1:0] step;
    word_t           quo;
    word_t           dvsr;
    word_t           a_mag;
    word_t           b_mag;
    word_t           rem_mag;
    logic            neg_q;
    logic            neg_r;
    logic            div_zero;

    assign a_mag = (is_signed && a[XLEN-1]) ? -a : a;
    assign b_mag = (is_signed && b[XLEN-1]) ? -b : b;

    assign last = (count == CW'(XLEN));

    // one extra bit so that twice the partial remainder cannot overflow
    assign shifted = {part_rem, quo[XLEN-1]};
    assign step    = part_rem[XLEN] ? shifted + {2'b00, dvsr} : shifted - {2'b00, dvsr};

    // a negative final remainder is one divisor short
    assign rem_mag = part_rem[XLEN] ? part_rem[XLEN-1:0] + dvsr : part_rem[XLEN-1:0];

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            busy     <= 1'b0;
            count    <= '0;
            div_done <= 1'b0;
        end else begin
            div_done <= busy & last;
            if (div_start) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (busy) begin
                if (last) begin
                    busy <= 1'b0;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (div_start) begin
            part_rem <= '0;
            quo      <= a_mag;  // dividend shifts out on top as quotient bits come in
            dvsr     <= b_mag;
            neg_q    <= is_signed & (a[XLEN-1] ^ b[XLEN-1]);
            neg_r    <= is_signed & a[XLEN-1];
            div_zero <= (b == '0);
        end else if (busy && !last) begin
            part_rem <= step[XLEN:0];
            quo      <= {quo[XLEN-2:0], ~step[XLEN+1]};
        end else if (busy) begin
            // most negative by minus one already yields itself after negation
            if (div_zero) begin
                quotient <= '1;
            end else begin
                quotient <= neg_q ? -quo : quo;
            end
            remainder <= neg_r ? -rem_mag : rem_mag;  // dividend comes back here on a zero divisor
        end
    end

endmodule

// ==== source/mdu_result.sv ====
// result register, holds the response word until the consumer takes it
`timescale 1ns/10ps

module mdu_result
    import mdu_data_pkg::*;
(
    input  logic     CLK,
    input  logic     RST,
    input  dword_t   product,
    input  logic     product_valid,
    input  word_t    quotient,
    input  word_t    remainder,
    input  logic     div_done,
    output mdu_rsp_t rsp,
    output logic     rsp_valid,
    input  logic     rsp_ready,
    output logic     rsp_taken
);

    mdu_result_u res;

    always_ff @(posedge CLK) begin
        if (product_valid) begin
            res.product <= product;
        end else if (div_done) begin
            res.division <= '{remainder: remainder, quotient: quotient};
        end
    end

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            rsp_valid <= 1'b0;
        end else if (product_valid || div_done) begin
            rsp_valid <= 1'b1;
        end else if (rsp_taken) begin
            rsp_valid <= 1'b0;
        end
    end

    // both views share one layout, so the upper and lower words go out as they are
    assign rsp = '{hi: res.product[2*XLEN-1:XLEN], lo: res.product[XLEN-1:0]};

    assign rsp_taken = rsp_valid & rsp_ready;

endmodule

// ==== source/mdu_top.sv ====
// multiply/divide unit top level, one request in flight at a time
`timescale 1ns/10ps

module mdu_top
    import mdu_data_pkg::*;
    import mdu_op_pkg::*;
(
    input  logic     CLK,
    input  logic     RST,
    input  mdu_req_t req,
    input  logic     req_valid,
    output logic     req_ready,
    output mdu_rsp_t rsp,
    output logic     rsp_valid,
    input  logic     rsp_ready
);

    word_t     a;
    word_t     b;
    mdu_ctrl_t ctrl;
    logic      mul_start;
    logic      div_start;
    dword_t    product;
    logic      product_valid;
    word_t     quotient;
    word_t     remainder;
    logic      div_done;
    logic      rsp_taken;

    mdu_decode u_decode (
        .CLK       (CLK),
        .RST       (RST),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp_taken (rsp_taken),
        .a         (a),
        .b         (b),
        .ctrl      (ctrl),
        .mul_start (mul_start),
        .div_start (div_start)
    );

    mdu_multiplier u_multiplier (
        .CLK           (CLK),
        .RST           (RST),
        .a             (a),
        .b             (b),
        .is_signed     (ctrl.is_signed),
        .mul_start     (mul_start),
        .product       (product),
        .product_valid (product_valid)
    );

    mdu_divider u_divider (
        .CLK       (CLK),
        .RST       (RST),
        .a         (a),
        .b         (b),
        .is_signed (ctrl.is_signed),
        .div_start (div_start),
        .quotient  (quotient),
        .remainder (remainder),
        .div_done  (div_done)
    );

    mdu_result u_result (
        .CLK           (CLK),
        .RST           (RST),
        .product       (product),
        .product_valid (product_valid),
        .quotient      (quotient),
        .remainder     (remainder),
        .div_done      (div_done),
        .rsp           (rsp),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .rsp_taken     (rsp_taken)
    );

endmodule

// ==== bench/mdu_clock.sv ====
// testbench clock and reset source, 10 ns clock with reset held for 10 cycles
`timescale 1ns/10ps

module mdu_clock (
    output logic CLK,
    output logic RST
);

    localparam int RESET_CYCLES = 10;

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;  // 10 ns period
    end

    initial begin
        RST = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        RST <= 1'b0;  // released half a cycle away from the rising edge
    end

endmodule

// ==== bench/mdu_properties.sv ====
// handshake assertions for the multiply/divide unit response and request ports
`timescale 1ns/10ps

module mdu_properties
    import mdu_data_pkg::*;
(
    input logic     CLK,
    input logic     RST,
    input logic     req_ready,
    input mdu_rsp_t rsp,
    input logic     rsp_valid,
    input logic     rsp_ready
);

    // a stalled response keeps both its valid and its data
    a_rsp_stable: assert property (@(posedge CLK) disable iff (RST)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else $error("response changed while the consumer stalled it");

    a_no_req_while_rsp: assert property (@(posedge CLK) disable iff (RST)
        rsp_valid |-> !req_ready)
        else $error("req_ready high while a response is still pending");

    a_rsp_idle_in_reset: assert property (@(posedge CLK) RST |-> !rsp_valid)
        else $error("rsp_valid high during reset");

endmodule

bind mdu_top mdu_properties u_properties (
    .CLK       (CLK),
    .RST       (RST),
    .req_ready (req_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready)
);

// ==== bench/mdu_tb.sv ====
// directed testbench for the multiply/divide unit with a behavioral reference model
`timescale 1ns/10ps

module mdu_tb
    import mdu_data_pkg::*;
    import mdu_op_pkg::*;
();

    localparam int    MAX_OPS        = 200;
    localparam int    MAX_OP_CYCLES  = 40;
    localparam int    TIMEOUT_CYCLES = MAX_OPS * MAX_OP_CYCLES * 5 / 2;
    localparam int    WAIT_LIMIT     = 2 * MAX_OP_CYCLES;
    localparam word_t MIN_WORD       = {1'b1, {(XLEN-1){1'b0}}};

    logic        CLK;
    logic        RST;
    mdu_req_t    req;
    logic        req_valid;
    logic        req_ready;
    mdu_rsp_t    rsp;
    logic        rsp_valid;
    logic        rsp_ready;
    logic [31:0] lfsr_state;
    int          cycle_count = 0;

    mdu_clock clock0 (.CLK(CLK), .RST(RST));

    mdu_top dut0 (
        .CLK       (CLK),
        .RST       (RST),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready)
    );

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure("timeout, the run went past its cycle limit");
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
    endfunction

    task automatic rand_bits(input int n, output word_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[XLEN-2:0], lfsr_state[0]};
        end
    endtask

    // quotient truncates toward zero and the remainder follows the dividend
    function automatic mdu_rsp_t expected_result(input mdu_op_e op, input word_t a, input word_t b);
        logic signed [XLEN-1:0]   sa;
        logic signed [XLEN-1:0]   sb;
        logic signed [2*XLEN-1:0] sp;
        mdu_rsp_t                 r;
        sa = a;
        sb = b;
        case (op)
            op_mul: begin
                sp = 64'(sa) * 64'(sb);
                r  = sp;
            end
            op_mulu: r = 64'(a) * 64'(b);
            op_div: begin
                if (b == '0) begin
                    r = '{hi: a, lo: '1};
                end else if (a == MIN_WORD && b == '1) begin
                    r = '{hi: '0, lo: MIN_WORD};
                end else begin
                    r = '{hi: sa % sb, lo: sa / sb};
                end
            end
            default: begin
                if (b == '0) begin
                    r = '{hi: a, lo: '1};
                end else begin
                    r = '{hi: a % b, lo: a / b};
                end
            end
        endcase
        return r;
    endfunction

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [2*XLEN-1:0] got,
                               input logic [2*XLEN-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic send_request(input mdu_op_e op, input word_t a, input word_t b);
        int n;
        n = 0;
        req       <= '{op: op, a: a, b: b};
        req_valid <= 1'b1;
        while (!req_ready) begin
            @(negedge CLK);
            n++;
            if (n > WAIT_LIMIT) begin
                report_failure("the request was never accepted");
            end
        end
        @(negedge CLK);  // accepted on the edge just passed
        req_valid <= 1'b0;
    endtask

    task automatic wait_response(output int latency);
        latency = 0;
        while (!rsp_valid) begin
            check_value("req_ready", req_ready, 1'b0);
            @(negedge CLK);
            latency++;
            if (latency > WAIT_LIMIT) begin
                report_failure("the response never arrived");
            end
        end
    endtask

    task automatic take_response(input string label, input int hold, input mdu_rsp_t exp);
        check_value(label, rsp, exp);
        for (int i = 0; i < hold; i++) begin
            @(negedge CLK);
            check_value("rsp_valid", rsp_valid, 1'b1);
            check_value("req_ready", req_ready, 1'b0);
            check_value(label, rsp, exp);
        end
        rsp_ready <= 1'b1;
        @(negedge CLK);
        rsp_ready <= 1'b0;
        check_value("rsp_valid", rsp_valid, 1'b0);
    endtask

    task automatic run_op(input mdu_op_e op, input word_t a, input word_t b, input int hold);
        mdu_rsp_t exp;
        int       latency;
        exp = expected_result(op, a, b);
        send_request(op, a, b);
        wait_response(latency);
        if (op == op_mul || op == op_mulu) begin
            check_value("multiply latency", latency, 2);  // rsp_valid after edge k+2
        end
        take_response($sformatf("rsp %s a %h b %h", op.name(), a, b), hold, exp);
    endtask

    task automatic test_reset();
        repeat (2) @(negedge CLK);
        while (RST) begin
            check_value("rsp_valid", rsp_valid, 1'b0);
            @(negedge CLK);
        end
        for (int i = 0; i < 5; i++) begin
            check_value("req_ready", req_ready, 1'b1);
            check_value("rsp_valid", rsp_valid, 1'b0);
            @(negedge CLK);
        end
    endtask

    task automatic test_multiply();
        word_t corner [5] = '{'0, 32'd1, '1, MIN_WORD, ~MIN_WORD};
        word_t a;
        word_t b;
        foreach (corner[i]) begin
            foreach (corner[j]) begin
                run_op(op_mul, corner[i], corner[j], 0);
                run_op(op_mulu, corner[i], corner[j], 0);
            end
        end
        for (int n = 0; n < 20; n++) begin
            rand_bits(XLEN, a);
            rand_bits(XLEN, b);
            run_op(op_mul, a, b, 0);
            run_op(op_mulu, a, b, 0);
        end
    endtask

    task automatic test_divide();
        word_t a;
        word_t b;
        word_t sh;
        for (int s = 0; s < 4; s++) begin
            for (int n = 0; n < 5; n++) begin
                rand_bits(XLEN - 1, a);
                rand_bits(5, sh);
                rand_bits(XLEN - 1, b);
                b = b >> sh;  // smaller divisors give quotients of every size
                a = s[1] ? -a : a;
                b = s[0] ? -b : b;
                run_op(op_div, a, b, 0);
                run_op(op_divu, a, b, 0);
            end
        end
    endtask

    task automatic test_corners();
        word_t dividend [5] = '{'0, 32'd7, '1, MIN_WORD, 32'h1234_5678};
        foreach (dividend[i]) begin
            run_op(op_div, dividend[i], '0, 0);
            run_op(op_divu, dividend[i], '0, 0);
        end
        run_op(op_div, MIN_WORD, '1, 0);
    endtask

    task automatic test_backpressure();
        mdu_rsp_t exp;
        mdu_op_e  op;
        word_t    sel;
        word_t    a;
        word_t    b;
        word_t    hold;
        int       latency;
        for (int n = 0; n < 8; n++) begin
            rand_bits(2, sel);
            rand_bits(XLEN, a);
            rand_bits(XLEN, b);
            rand_bits(4, hold);
            op  = mdu_op_e'(sel[1:0]);
            exp = expected_result(op, a, b);
            send_request(op, a, b);
            wait_response(latency);
            req       <= '{op: op_mulu, a: b, b: a};  // a second request waits behind the stall
            req_valid <= 1'b1;
            take_response($sformatf("rsp %s a %h b %h", op.name(), a, b), hold + 1, exp);
            run_op(op_mulu, b, a, 0);
        end
    endtask

    initial begin
        lfsr_state = 32'h3ae0a6bc;
        req        = '0;
        req_valid  = 1'b0;
        rsp_ready  = 1'b0;
        test_reset();
        test_multiply();
        test_divide();
        test_corners();
        test_backpressure();
        $display("test passed");
        $finish;
    end

endmodule

// ==== list.f ====
source/mdu_data_pkg.sv
source/mdu_op_pkg.sv
source/mdu_decode.sv
source/mdu_multiplier.sv
source/mdu_divider.sv
source/mdu_result.sv
source/mdu_top.sv
bench/mdu_clock.sv
bench/mdu_properties.sv
bench/mdu_tb.sv

// ==== Bender.yml ====
package:
  name: mdu

sources:
  - source/mdu_data_pkg.sv
  - source/mdu_op_pkg.sv
  - source/mdu_decode.sv
  - source/mdu_multiplier.sv
  - source/mdu_divider.sv
  - source/mdu_result.sv
  - source/mdu_top.sv
  - target: test
    files:
      - bench/mdu_clock.sv
      - bench/mdu_properties.sv
      - bench/mdu_tb.sv
